// ==== project.f ====
logic/coreDefs.sv
logic/regFile.sv
logic/instDecode.sv
logic/aluExecute.sv
logic/lsuWishbone.sv
logic/resultCommit.sv
logic/coreTop.sv
sim/tbMemory.sv
sim/coreTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module coreTb -f project.f -o coreSim \
  && ./obj_dir/coreSim | tee sim.log \
  || echo "verilator build or run error"
grep -qs "Simulation completed successfully" sim.log && exit 0 || exit 1

// ==== sim/coreTb.sv ====
`default_nettype none

module coreTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxRows = 40;
  localparam int timeoutCycles = 50;
  localparam int resetCycles = 16;
  localparam logic [31:0] seed = 32'h34ee_a422;

  localparam logic [6:0] iOp     = 7'h13;
  localparam logic [6:0] loadOp  = 7'h03;
  localparam logic [6:0] storeOp = 7'h23;
  localparam logic [6:0] jalrOp  = 7'h67;
  localparam logic [6:0] luiOp   = 7'h37;
  localparam logic [6:0] auipcOp = 7'h17;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] instAddr, inst, wbAdr, wbDatW, wbDatR;
  logic        wbCyc, wbStb, wbWe, wbAck;
  logic [3:0]  wbSel;
  logic        retireValid, retireWe;
  logic [31:0] retirePc, retireData;
  logic [4:0]  retireRd;

  // one row per retired instruction in program order
  logic [31:0] rowInst [maxRows];
  logic [31:0] rowPc [maxRows];
  logic [4:0]  rowRd [maxRows];
  logic        rowWe [maxRows];
  logic [31:0] rowData [maxRows];
  int          rows = 0;
  int          stepErrors = 0;
  int          passCount = 0;
  int          failCount = 0;
  bit          timedOut = 1'b0;

  always #10 clk = ~clk;

  coreTop uut (
    .clk, .rst, .instAddr, .inst,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbSel, .wbDatR, .wbAck,
    .retireValid, .retirePc, .retireRd, .retireWe, .retireData
  );

  tbMemory #(.lcgSeed(seed)) mem (
    .clk, .rst, .instAddr, .inst,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbSel, .wbDatR, .wbAck
  );

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], storeOp};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] uType(input logic [19:0] upper, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {upper, rd, op};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic bit isMemOp(input logic [31:0] word);
    return (word[6:0] == loadOp) || (word[6:0] == storeOp);
  endfunction

  task automatic addRow(input logic [31:0] word, input logic [31:0] pc, input logic [4:0] rd,
                        input logic we, input logic [31:0] data);
    rowInst[rows] = word;
    rowPc[rows]   = pc;
    rowRd[rows]   = rd;
    rowWe[rows]   = we;
    rowData[rows] = data;
    rows++;
  endtask

  task automatic buildTable();
    addRow(iType(12'd5, 5'd0, 3'b000, 5'd1, iOp), 32'h00, 5'd1, 1'b1, 32'h5);
    addRow(iType(12'hffd, 5'd0, 3'b000, 5'd2, iOp), 32'h04, 5'd2, 1'b1, 32'hffff_fffd);
    addRow(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 32'h08, 5'd3, 1'b1, 32'h8);
    addRow(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd4), 32'h0c, 5'd4, 1'b1, 32'h5);
    addRow(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd5), 32'h10, 5'd5, 1'b1, 32'hffff_fffd);
    addRow(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd6), 32'h14, 5'd6, 1'b1, 32'hffff_fff8);
    addRow(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 32'h18, 5'd7, 1'b1, 32'h1);
    addRow(rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd8), 32'h1c, 5'd8, 1'b1, 32'h0);
    addRow(iType(12'h004, 5'd1, 3'b001, 5'd9, iOp), 32'h20, 5'd9, 1'b1, 32'h50);
    addRow(iType(12'h401, 5'd2, 3'b101, 5'd10, iOp), 32'h24, 5'd10, 1'b1, 32'hffff_fffe);
    addRow(iType(12'h01c, 5'd2, 3'b101, 5'd11, iOp), 32'h28, 5'd11, 1'b1, 32'hf);
    addRow(rType(7'h00, 5'd1, 5'd1, 3'b001, 5'd12), 32'h2c, 5'd12, 1'b1, 32'ha0);
    addRow(iType(12'd7, 5'd1, 3'b000, 5'd0, iOp), 32'h30, 5'd0, 1'b1, 32'hc);  // into x0
    addRow(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd13), 32'h34, 5'd13, 1'b1, 32'h0);
    addRow(uType(20'h12345, 5'd14, luiOp), 32'h38, 5'd14, 1'b1, 32'h1234_5000);
    addRow(uType(20'h00001, 5'd15, auipcOp), 32'h3c, 5'd15, 1'b1, 32'h103c);
    addRow(iType(12'h100, 5'd0, 3'b000, 5'd16, iOp), 32'h40, 5'd16, 1'b1, 32'h100);
    addRow(sType(12'd8, 5'd14, 5'd16), 32'h44, 5'd0, 1'b0, 32'h0);
    addRow(iType(12'd8, 5'd16, 3'b010, 5'd17, loadOp), 32'h48, 5'd17, 1'b1, 32'h1234_5000);
    addRow(sType(12'd12, 5'd6, 5'd16), 32'h4c, 5'd0, 1'b0, 32'h0);
    addRow(iType(12'd12, 5'd16, 3'b010, 5'd18, loadOp), 32'h50, 5'd18, 1'b1, 32'hffff_fff8);
    addRow(bType(13'd8, 5'd2, 5'd1, 3'b000), 32'h54, 5'd0, 1'b0, 32'h0);  // beq not taken
    addRow(bType(13'd8, 5'd2, 5'd1, 3'b001), 32'h58, 5'd0, 1'b0, 32'h0);
    addRow(bType(13'd8, 5'd1, 5'd2, 3'b100), 32'h60, 5'd0, 1'b0, 32'h0);
    addRow(bType(13'd8, 5'd1, 5'd2, 3'b101), 32'h68, 5'd0, 1'b0, 32'h0);  // bge not taken
    addRow(bType(13'd8, 5'd1, 5'd1, 3'b101), 32'h6c, 5'd0, 1'b0, 32'h0);
    addRow(jType(21'd12, 5'd19), 32'h74, 5'd19, 1'b1, 32'h78);
    addRow(iType(12'h091, 5'd0, 3'b000, 5'd20, iOp), 32'h80, 5'd20, 1'b1, 32'h91);
    addRow(iType(12'h00c, 5'd20, 3'b000, 5'd21, jalrOp), 32'h84, 5'd21, 1'b1, 32'h88);
    addRow(rType(7'h00, 5'd21, 5'd19, 3'b000, 5'd22), 32'h9c, 5'd22, 1'b1, 32'h100);
    addRow(iType(12'd8, 5'd16, 3'b010, 5'd23, loadOp), 32'ha0, 5'd23, 1'b1, 32'h1234_5000);
    // reads back the RAM fill pattern
    addRow(iType(12'h020, 5'd16, 3'b010, 5'd24, loadOp), 32'ha4, 5'd24, 1'b1, 32'hd00d_0120);
  endtask

  task automatic compareField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      stepErrors++;
    end
  endtask

  initial begin
    int waited;
    rst = 1'b1;
    buildTable();
    for (int i = 0; i < 64; i++) begin
      mem.rom[i] = iType(12'(i * 4), 5'd0, 3'b000, 5'd0, iOp);  // addi x0 with its address
    end
    for (int i = 0; i < rows; i++) begin
      mem.rom[rowPc[i][7:2]] = rowInst[i];
    end

    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < rows && !timedOut; i++) begin
      stepErrors = 0;
      waited = 0;
      while (retireValid !== 1'b1 && waited < timeoutCycles) begin
        compareField("retirePc", rowPc[i], retirePc);  // pc held during the bus wait
        @(negedge clk);
        waited++;
      end
      assert (retireValid === 1'b1) else begin
        $display("Step %0d retired nothing within %0d cycles", i, timeoutCycles);
        timedOut = 1'b1;
      end
      if (!timedOut) begin
        compareField("retirePc", rowPc[i], retirePc);
        compareField("instAddr", rowPc[i], instAddr);
        compareField("retireWe", 32'(rowWe[i]), 32'(retireWe));
        if (rowWe[i]) begin
          compareField("retireRd", 32'(rowRd[i]), 32'(retireRd));
          compareField("retireData", rowData[i], retireData);
        end
        if (isMemOp(rowInst[i])) begin
          compareField("wbAck", 32'd1, 32'(wbAck));
          compareField("wbStb", 32'd1, 32'(wbStb));
          compareField("wbWe", 32'(rowInst[i][6:0] == storeOp), 32'(wbWe));
          compareField("wbSel", 32'hf, 32'(wbSel));
        end else begin
          compareField("wbCyc", 32'd0, 32'(wbCyc));  // bus idle outside loads and stores
          compareField("wbStb", 32'd0, 32'(wbStb));
        end
        @(negedge clk);
      end
      if (stepErrors == 0 && !timedOut) begin
        passCount++;
        $display("step %0d pc %h ok", i, rowPc[i]);
      end else begin
        failCount++;
        $display("step %0d pc %h had %0d mismatches", i, rowPc[i], stepErrors);
      end
    end

    $display("%0d of %0d steps passed, %0d with errors", passCount, rows, failCount);
    if (failCount == 0 && passCount == rows) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tbMemory.sv ====
`default_nettype none

module tbMemory #(
  parameter logic [31:0] lcgSeed = 32'h0000_0001
) (
  input  wire         clk,
  input  wire         rst,
  input  wire  [31:0] instAddr,
  output logic [31:0] inst,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire  [31:0] wbAdr,
  input  wire  [31:0] wbDatW,
  input  wire  [3:0]  wbSel,
  output logic [31:0] wbDatR,
  output logic        wbAck
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rom [0:63];  // filled by the testbench top
  logic [31:0] ram [0:255];
  logic [31:0] rngState = lcgSeed;
  logic [31:0] readReg = 32'h0;
  logic        ackReg = 1'b0;
  logic        counting = 1'b0;
  logic [1:0]  waitLeft = 2'd0;

  function automatic logic [31:0] nextRand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      ram[i] = 32'hd00d_0000 + 32'(i * 4);  // byte address in the low half
    end
  end

  assign inst   = rom[instAddr[7:2]];
  assign wbDatR = readReg;
  assign wbAck  = ackReg;

  // classic slave, one fixed cycle plus a random 0 to 3 wait cycles
  always @(posedge clk) begin
    if (rst) begin
      ackReg   <= 1'b0;
      counting <= 1'b0;
      waitLeft <= 2'd0;
      rngState <= lcgSeed;
    end else begin
      ackReg <= 1'b0;
      if (wbCyc && wbStb && !ackReg) begin
        if (!counting) begin
          counting <= 1'b1;
          waitLeft <= rngState[31:30];  // upper bits, the low ones repeat fast
          rngState <= nextRand(rngState);
        end else if (waitLeft != 2'd0) begin
          waitLeft <= waitLeft - 2'd1;
        end else begin
          counting <= 1'b0;
          ackReg   <= 1'b1;  // single cycle ack
          if (!wbWe) begin
            readReg <= ram[wbAdr[9:2]];
          end else if (wbSel == 4'b1111) begin
            ram[wbAdr[9:2]] <= wbDatW;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/coreTop.sv ====
`default_nettype none

module coreTop (
  input  wire                       clk,
  input  wire                       rst,
  output logic [coreDefs::xlen-1:0] instAddr,
  input  wire  [31:0]               inst,
  output logic                      wbCyc,
  output logic                      wbStb,
  output logic                      wbWe,
  output logic [coreDefs::xlen-1:0] wbAdr,
  output logic [coreDefs::xlen-1:0] wbDatW,
  output logic [3:0]                wbSel,
  input  wire  [coreDefs::xlen-1:0] wbDatR,
  input  wire                       wbAck,
  output logic                      retireValid,
  output logic [coreDefs::xlen-1:0] retirePc,
  output logic [4:0]                retireRd,
  output logic                      retireWe,
  output logic [coreDefs::xlen-1:0] retireData
);
  import coreDefs::*;

  logic [4:0]      rs1, rs2, rd, regRd;
  logic [xlen-1:0] rs1Data, rs2Data, regData, imm, pc;
  logic [xlen-1:0] aluResult, loadData;
  aluOp_t          aluOp;
  srcASel_t        srcASel;
  branch_t         branch;
  wbSel_t          wbSrc;  // writeback source, not the bus byte select
  logic            useImm, memRead, memWrite, rdWe, regWe;
  logic            branchTaken, memDone, stall;

  assign instAddr = pc;

  regFile regs (
    .clk, .rst, .rs1, .rs2, .rs1Data, .rs2Data,
    .we(regWe), .rd(regRd), .rdData(regData)
  );

  instDecode decode (
    .inst, .rs1, .rs2, .rd, .imm, .aluOp, .srcASel, .useImm, .branch,
    .memRead, .memWrite, .wbSel(wbSrc), .rdWe
  );

  aluExecute alu (
    .rs1Data, .rs2Data, .pc, .imm, .aluOp, .srcASel, .useImm, .branch,
    .aluResult, .branchTaken
  );

  lsuWishbone lsu (
    .clk, .rst, .memRead, .memWrite, .addr(aluResult), .storeData(rs2Data),
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbSel, .wbDatR, .wbAck,
    .loadData, .memDone, .stall
  );

  resultCommit commit (
    .clk, .rst, .stall, .memDone, .wbSel(wbSrc), .rdWe, .rd, .aluResult,
    .loadData, .imm, .rs1Data, .branch, .branchTaken, .pc,
    .regWe, .regRd, .regData,
    .retireValid, .retirePc, .retireRd, .retireWe, .retireData
  );

endmodule

`default_nettype wire

// ==== logic/resultCommit.sv ====
`default_nettype none

module resultCommit (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       stall,
  input  wire                       memDone,
  input  wire  coreDefs::wbSel_t    wbSel,
  input  wire                       rdWe,
  input  wire  [4:0]                rd,
  input  wire  [coreDefs::xlen-1:0] aluResult,
  input  wire  [coreDefs::xlen-1:0] loadData,
  input  wire  [coreDefs::xlen-1:0] imm,
  input  wire  [coreDefs::xlen-1:0] rs1Data,
  input  wire  coreDefs::branch_t   branch,
  input  wire                       branchTaken,
  output logic [coreDefs::xlen-1:0] pc,
  output logic                      regWe,
  output logic [4:0]                regRd,
  output logic [coreDefs::xlen-1:0] regData,
  output logic                      retireValid,
  output logic [coreDefs::xlen-1:0] retirePc,
  output logic [4:0]                retireRd,
  output logic                      retireWe,
  output logic [coreDefs::xlen-1:0] retireData
);
  import coreDefs::*;

  logic [xlen-1:0] pcPlus4, jalrSum, nextPc;

  assign pcPlus4 = pc + xlen'(4);
  assign jalrSum = rs1Data + imm;

  always_comb begin
    if (branch == brJalr)  nextPc = {jalrSum[xlen-1:1], 1'b0};
    else if (branchTaken)  nextPc = pc + imm;  // taken branch or jal
    else                   nextPc = pcPlus4;
  end

  always_ff @(posedge clk) begin
    if (rst)         pc <= resetPc;
    else if (!stall) pc <= nextPc;
  end

  always_comb begin
    case (wbSel)
      wbMem:     regData = loadData;
      wbPcPlus4: regData = pcPlus4;
      default:   regData = aluResult;
    endcase
  end

  assign regWe = rdWe && !stall;  // held off until the bus acks
  assign regRd = rd;

  assign retireValid = !stall;
  assign retirePc    = pc;
  assign retireRd    = rd;
  assign retireWe    = regWe;
  assign retireData  = regData;

  // a load may only retire on the ack cycle of its bus transfer
  loadOnAck: assert property (
    @(posedge clk) disable iff (rst)
    (wbSel == wbMem && !stall) |-> memDone
  );

endmodule

`default_nettype wire

// ==== logic/lsuWishbone.sv ====
`default_nettype none

module lsuWishbone (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       memRead,
  input  wire                       memWrite,
  input  wire  [coreDefs::xlen-1:0] addr,
  input  wire  [coreDefs::xlen-1:0] storeData,
  output logic                      wbCyc,
  output logic                      wbStb,
  output logic                      wbWe,
  output logic [coreDefs::xlen-1:0] wbAdr,
  output logic [coreDefs::xlen-1:0] wbDatW,
  output logic [3:0]                wbSel,
  input  wire  [coreDefs::xlen-1:0] wbDatR,
  input  wire                       wbAck,
  output logic [coreDefs::xlen-1:0] loadData,
  output logic                      memDone,
  output logic                      stall
);
  import coreDefs::*;

  typedef enum logic {idle, busy} lsuState_t;

  lsuState_t       state, stateNext;
  logic            request;
  logic [xlen-1:0] adrHeld, datHeld;
  logic            weHeld;

  assign request = memRead || memWrite;

  always_comb begin
    stateNext = state;
    case (state)
      idle:    if (request && !wbAck) stateNext = busy;
      default: if (wbAck) stateNext = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= idle;
    else     state <= stateNext;
  end

  // capture the request on the first cycle of the transfer
  always_ff @(posedge clk) begin
    if (state == idle && request) begin
      adrHeld <= addr;
      datHeld <= storeData;
      weHeld  <= memWrite;
    end
  end

  assign wbCyc  = (state == busy) || request;  // first cycle straight from decode
  assign wbStb  = wbCyc;
  assign wbWe   = (state == busy) ? weHeld : memWrite;
  assign wbAdr  = (state == busy) ? adrHeld : addr;
  assign wbDatW = (state == busy) ? datHeld : storeData;
  assign wbSel  = 4'b1111;  // word access only

  assign loadData = wbDatR;
  assign memDone  = wbCyc && wbAck;
  assign stall    = wbCyc && !wbAck;

  busHeld: assert property (
    @(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW))
  );

  wordAligned: assert property (
    @(posedge clk) disable iff (rst)
    wbCyc |-> (wbAdr[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

// ==== logic/aluExecute.sv ====
`default_nettype none

module aluExecute (
  input  wire  [coreDefs::xlen-1:0] rs1Data,
  input  wire  [coreDefs::xlen-1:0] rs2Data,
  input  wire  [coreDefs::xlen-1:0] pc,
  input  wire  [coreDefs::xlen-1:0] imm,
  input  wire  coreDefs::aluOp_t    aluOp,
  input  wire  coreDefs::srcASel_t  srcASel,
  input  wire                       useImm,
  input  wire  coreDefs::branch_t   branch,
  output logic [coreDefs::xlen-1:0] aluResult,
  output logic                      branchTaken
);
  import coreDefs::*;

  logic [xlen-1:0] opA, opB;
  logic [4:0]      shamt;
  logic            ltSigned, ltUnsigned, isEqual;

  assign opA   = (srcASel == srcPc) ? pc : rs1Data;
  assign opB   = useImm ? imm : rs2Data;
  assign shamt = opB[4:0];

  assign ltSigned   = $signed(opA) < $signed(opB);
  assign ltUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      aluAdd:   aluResult = opA + opB;
      aluSub:   aluResult = opA - opB;
      aluAnd:   aluResult = opA & opB;
      aluOr:    aluResult = opA | opB;
      aluXor:   aluResult = opA ^ opB;
      aluSlt:   aluResult = {{(xlen-1){1'b0}}, ltSigned};
      aluSltu:  aluResult = {{(xlen-1){1'b0}}, ltUnsigned};
      aluSll:   aluResult = opA << shamt;
      aluSrl:   aluResult = opA >> shamt;
      aluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
      default:  aluResult = opB;  // passB
    endcase
  end

  // branches compare the registers, not the muxed operands
  assign isEqual = rs1Data == rs2Data;

  always_comb begin
    case (branch)
      brEq:    branchTaken = isEqual;
      brNe:    branchTaken = !isEqual;
      brLt:    branchTaken = $signed(rs1Data) < $signed(rs2Data);
      brGe:    branchTaken = $signed(rs1Data) >= $signed(rs2Data);
      brJal,
      brJalr:  branchTaken = 1'b1;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/instDecode.sv ====
`default_nettype none

module instDecode (
  input  wire  [31:0]               inst,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  output logic [4:0]                rd,
  output logic [coreDefs::xlen-1:0] imm,
  output coreDefs::aluOp_t          aluOp,
  output coreDefs::srcASel_t        srcASel,
  output logic                      useImm,
  output coreDefs::branch_t         branch,
  output logic                      memRead,
  output logic                      memWrite,
  output coreDefs::wbSel_t          wbSel,
  output logic                      rdWe
);
  import coreDefs::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] immI, immS, immB, immU, immJ;
  aluOp_t          arithOp;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct3 mapping shared by op and op-imm
  always_comb begin
    case (funct3)
      3'b000:  arithOp = (opcode == opReg && inst[30]) ? aluSub : aluAdd;
      3'b001:  arithOp = aluSll;
      3'b010:  arithOp = aluSlt;
      3'b011:  arithOp = aluSltu;
      3'b100:  arithOp = aluXor;
      3'b101:  arithOp = inst[30] ? aluSra : aluSrl;
      3'b110:  arithOp = aluOr;
      default: arithOp = aluAnd;
    endcase
  end

  always_comb begin
    aluOp    = aluAdd;
    srcASel  = srcReg;
    useImm   = 1'b0;
    imm      = '0;
    branch   = brNone;
    memRead  = 1'b0;
    memWrite = 1'b0;
    wbSel    = wbAlu;
    rdWe     = 1'b0;
    case (opcode)
      opLui: begin
        imm    = immU;
        aluOp  = aluPassB;
        useImm = 1'b1;
        rdWe   = 1'b1;
      end
      opAuipc: begin
        imm     = immU;
        srcASel = srcPc;
        useImm  = 1'b1;
        rdWe    = 1'b1;
      end
      opJal: begin
        imm    = immJ;
        branch = brJal;
        wbSel  = wbPcPlus4;
        rdWe   = 1'b1;
      end
      opJalr: begin
        imm    = immI;
        useImm = 1'b1;
        branch = brJalr;
        wbSel  = wbPcPlus4;
        rdWe   = 1'b1;
      end
      opBranch: begin
        imm = immB;
        case (funct3)
          3'b000:  branch = brEq;
          3'b001:  branch = brNe;
          3'b100:  branch = brLt;
          3'b101:  branch = brGe;
          default: branch = brNone;  // bltu/bgeu not supported
        endcase
      end
      opLoad: begin
        imm     = immI;
        useImm  = 1'b1;
        memRead = 1'b1;
        wbSel   = wbMem;
        rdWe    = 1'b1;
      end
      opStore: begin
        imm      = immS;
        useImm   = 1'b1;
        memWrite = 1'b1;
      end
      opImm: begin
        imm    = immI;
        useImm = 1'b1;
        aluOp  = arithOp;
        rdWe   = 1'b1;
      end
      opReg: begin
        aluOp = arithOp;
        rdWe  = 1'b1;
      end
      default: ;  // illegal, retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`default_nettype none

module regFile (
  input  wire                       clk,
  input  wire                       rst,
  input  wire  [4:0]                rs1,
  input  wire  [4:0]                rs2,
  output logic [coreDefs::xlen-1:0] rs1Data,
  output logic [coreDefs::xlen-1:0] rs2Data,
  input  wire                       we,
  input  wire  [4:0]                rd,
  input  wire  [coreDefs::xlen-1:0] rdData
);
  import coreDefs::*;

  logic [xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= rdData;
    end
  end

  assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // catches undriven fetch data feeding the register addresses
  readNotX: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({rs1Data, rs2Data})
  );

endmodule

`default_nettype wire

// ==== logic/coreDefs.sv ====
`default_nettype none

package coreDefs;

  localparam int xlen = 32;

  localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSltu,
    aluSll,
    aluSrl,
    aluSra,
    aluPassB  // lui, operand b straight through
  } aluOp_t;

  typedef enum logic [2:0] {
    brNone,
    brEq,
    brNe,
    brLt,
    brGe,
    brJal,
    brJalr
  } branch_t;

  // writeback source
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbPcPlus4
  } wbSel_t;

  typedef enum logic {
    srcReg,
    srcPc  // auipc
  } srcASel_t;

endpackage

`default_nettype wire
